// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --assert --timescale 1ns/1ns
TOP      = tb_acc_buffers
FILELIST = acc_buffers.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "Test OK" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== acc_buffers.f ====
rtl/buf_cfg_pkg.sv
rtl/sram_cfg_pkg.sv
rtl/sram_if.sv
rtl/sram_sp.sv
rtl/stream_buffer.sv
rtl/acc_buffers.sv
verif/acc_buffers_assertions.sv
verif/tb_acc_buffers.sv

// ==== rtl/acc_buffers.sv ====
`timescale 1ns/1ns
`default_nettype none

module acc_buffers (
    input  logic                                                 i_clk,
    input  logic                                                 i_rst_n,

    // input activations.
    input  logic                                                 i_ibuf_wr_valid,
    output logic                                                 o_ibuf_wr_ready,
    input  buf_cfg_pkg::data_t    [buf_cfg_pkg::IBUF_BANKS-1:0]  i_ibuf_wr_data,
    output logic                                                 o_ibuf_rd_valid,
    input  logic                                                 i_ibuf_rd_ready,
    output buf_cfg_pkg::data_t    [buf_cfg_pkg::IBUF_BANKS-1:0]  o_ibuf_rd_data,

    // weights.
    input  logic                                                 i_wbuf_wr_valid,
    output logic                                                 o_wbuf_wr_ready,
    input  buf_cfg_pkg::data_t    [buf_cfg_pkg::WBUF_BANKS-1:0]  i_wbuf_wr_data,
    output logic                                                 o_wbuf_rd_valid,
    input  logic                                                 i_wbuf_rd_ready,
    output buf_cfg_pkg::data_t    [buf_cfg_pkg::WBUF_BANKS-1:0]  o_wbuf_rd_data,

    // partial sums.
    input  logic                                                 i_gbuf_wr_valid,
    output logic                                                 o_gbuf_wr_ready,
    input  buf_cfg_pkg::gb_data_t [buf_cfg_pkg::GBUF_BANKS-1:0]  i_gbuf_wr_data,
    output logic                                                 o_gbuf_rd_valid,
    input  logic                                                 i_gbuf_rd_ready,
    output buf_cfg_pkg::gb_data_t [buf_cfg_pkg::GBUF_BANKS-1:0]  o_gbuf_rd_data
);

    import buf_cfg_pkg::*;

    //////////////////////////////////////////////////
    // input activation buffer
    //////////////////////////////////////////////////

    stream_buffer #(
        .BANKS  (IBUF_BANKS),
        .DEPTH  (IBUF_DEPTH),
        .DATA_W (DATA_W)
    ) u_ibuf (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_wr_valid (i_ibuf_wr_valid),
        .o_wr_ready (o_ibuf_wr_ready),
        .i_wr_data  (i_ibuf_wr_data),
        .o_rd_valid (o_ibuf_rd_valid),
        .i_rd_ready (i_ibuf_rd_ready),
        .o_rd_data  (o_ibuf_rd_data)
    );

    //////////////////////////////////////////////////
    // weight buffer
    //////////////////////////////////////////////////

    stream_buffer #(
        .BANKS  (WBUF_BANKS),
        .DEPTH  (WBUF_DEPTH),
        .DATA_W (DATA_W)
    ) u_wbuf (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_wr_valid (i_wbuf_wr_valid),
        .o_wr_ready (o_wbuf_wr_ready),
        .i_wr_data  (i_wbuf_wr_data),
        .o_rd_valid (o_wbuf_rd_valid),
        .i_rd_ready (i_wbuf_rd_ready),
        .o_rd_data  (o_wbuf_rd_data)
    );

    //////////////////////////////////////////////////
    // global buffer
    //////////////////////////////////////////////////

    // wider words, fewer banks.
    stream_buffer #(
        .BANKS  (GBUF_BANKS),
        .DEPTH  (GBUF_DEPTH),
        .DATA_W (GB_DATA_W)
    ) u_gbuf (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_wr_valid (i_gbuf_wr_valid),
        .o_wr_ready (o_gbuf_wr_ready),
        .i_wr_data  (i_gbuf_wr_data),
        .o_rd_valid (o_gbuf_rd_valid),
        .i_rd_ready (i_gbuf_rd_ready),
        .o_rd_data  (o_gbuf_rd_data)
    );

endmodule

`default_nettype wire

// ==== rtl/buf_cfg_pkg.sv ====
`default_nettype none

package buf_cfg_pkg;

    //////////////////////////////////////////////////
    // word widths
    //////////////////////////////////////////////////

    localparam int unsigned DATA_W    = 16;  // activation and weight word.
    localparam int unsigned GB_DATA_W = 32;  // partial-sum word.

    //////////////////////////////////////////////////
    // buffer geometry
    //////////////////////////////////////////////////

    localparam int unsigned IBUF_BANKS = 4;
    localparam int unsigned WBUF_BANKS = 4;
    localparam int unsigned GBUF_BANKS = 2;

    localparam int unsigned IBUF_DEPTH = 16;  // words per bank.
    localparam int unsigned WBUF_DEPTH = 16;
    localparam int unsigned GBUF_DEPTH = 8;

    //////////////////////////////////////////////////
    // types
    //////////////////////////////////////////////////

    typedef logic [DATA_W-1:0]    data_t;     // one ibuf or wbuf bank word.
    typedef logic [GB_DATA_W-1:0] gb_data_t;  // one gbuf bank word.

    // a buffer either takes writes or streams them back.
    typedef enum logic {
        BUF_FILL  = 1'b0,
        BUF_DRAIN = 1'b1
    } buf_phase_e;

endpackage

`default_nettype wire

// ==== rtl/sram_cfg_pkg.sv ====
`default_nettype none

package sram_cfg_pkg;

    //////////////////////////////////////////////////
    // single-port sram
    //////////////////////////////////////////////////

    // one access per cycle, so the port is either reading or writing.
    typedef enum logic {
        SRAM_READ  = 1'b0,
        SRAM_WRITE = 1'b1
    } sram_mode_e;

    localparam int unsigned SRAM_READ_LAT = 1;  // cycles from read to rdata.

endpackage

`default_nettype wire

// ==== rtl/sram_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface sram_if #(
    parameter int unsigned ADDR_W = 4,
    parameter int unsigned DATA_W = 16
);

    import sram_cfg_pkg::*;

    logic              ce;     // access this cycle.
    sram_mode_e        mode;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [DATA_W-1:0] rdata;  // registered read word.

    // buffer controller side.
    modport ctrl (
        output ce,
        output mode,
        output addr,
        output wdata,
        input  rdata
    );

    // memory bank side.
    modport mem (
        input  ce,
        input  mode,
        input  addr,
        input  wdata,
        output rdata
    );

endinterface

`default_nettype wire

// ==== rtl/sram_sp.sv ====
`timescale 1ns/1ns
`default_nettype none

module sram_sp #(
    parameter int unsigned DEPTH  = 16,
    parameter int unsigned DATA_W = 16
) (
    input logic i_clk,
    sram_if.mem bus
);

    import sram_cfg_pkg::*;

    logic [DATA_W-1:0] mem_q [DEPTH];
    logic [DATA_W-1:0] rd_pipe_q [SRAM_READ_LAT];

    logic wr_en;
    logic rd_en;

    assign wr_en = bus.ce && (bus.mode == SRAM_WRITE);
    assign rd_en = bus.ce && (bus.mode == SRAM_READ);

    //////////////////////////////////////////////////
    // array
    //////////////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (wr_en) begin
            mem_q[bus.addr] <= bus.wdata;
        end
    end

    //////////////////////////////////////////////////
    // read port
    //////////////////////////////////////////////////

    // first stage holds its word until the next read.
    always_ff @(posedge i_clk) begin
        if (rd_en) begin
            rd_pipe_q[0] <= mem_q[bus.addr];
        end
        for (int s = 1; s < SRAM_READ_LAT; s++) begin
            rd_pipe_q[s] <= rd_pipe_q[s-1];
        end
    end

    assign bus.rdata = rd_pipe_q[SRAM_READ_LAT-1];

endmodule

`default_nettype wire

// ==== rtl/stream_buffer.sv ====
`timescale 1ns/1ns
`default_nettype none

module stream_buffer #(
    parameter int unsigned BANKS  = 4,
    parameter int unsigned DEPTH  = 16,
    parameter int unsigned DATA_W = 16
) (
    input  logic                    i_clk,
    input  logic                    i_rst_n,

    input  logic                    i_wr_valid,
    output logic                    o_wr_ready,
    input  logic [BANKS*DATA_W-1:0] i_wr_data,

    output logic                    o_rd_valid,
    input  logic                    i_rd_ready,
    output logic [BANKS*DATA_W-1:0] o_rd_data
);

    import buf_cfg_pkg::*;
    import sram_cfg_pkg::*;

    localparam int unsigned       ADDR_W    = $clog2(DEPTH);
    localparam int unsigned       CNT_W     = $clog2(DEPTH + 1);
    localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(DEPTH - 1);
    localparam logic [CNT_W-1:0]  LAST_CNT  = CNT_W'(DEPTH - 1);
    localparam logic [CNT_W-1:0]  FULL_CNT  = CNT_W'(DEPTH);

    buf_phase_e               phase_q;
    logic [ADDR_W-1:0]        addr_q;      // shared by every bank.
    logic [CNT_W-1:0]         rd_cnt_q;    // reads issued this drain.
    logic [CNT_W-1:0]         out_cnt_q;   // beats delivered this drain.
    logic [SRAM_READ_LAT-1:0] rd_pend_q;   // word waiting on sram rdata.
    logic                     out_vld_q;
    logic [BANKS*DATA_W-1:0]  out_data_q;

    logic                     wr_fire;
    logic                     rd_fire;
    logic                     rd_issue;
    logic                     ld_out;
    logic                     sram_ce;
    sram_mode_e               sram_mode;
    logic [BANKS*DATA_W-1:0]  bank_rdata;

    //////////////////////////////////////////////////
    // handshakes
    //////////////////////////////////////////////////

    assign o_wr_ready = (phase_q == BUF_FILL);
    assign o_rd_valid = out_vld_q;
    assign o_rd_data  = out_data_q;

    assign wr_fire = i_wr_valid && o_wr_ready;
    assign rd_fire = out_vld_q && i_rd_ready;

    // output reg free now or freed this cycle.
    assign ld_out   = rd_pend_q[SRAM_READ_LAT-1] && (!out_vld_q || rd_fire);
    assign rd_issue = (phase_q == BUF_DRAIN) && (rd_cnt_q != FULL_CNT)
                      && (!out_vld_q || rd_fire);

    assign sram_ce   = wr_fire || rd_issue;
    assign sram_mode = (phase_q == BUF_FILL) ? SRAM_WRITE : SRAM_READ;

    //////////////////////////////////////////////////
    // phase fsm
    //////////////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            phase_q <= BUF_FILL;
        end else begin
            case (phase_q)
                BUF_FILL: begin
                    if (wr_fire && (addr_q == LAST_ADDR)) begin
                        phase_q <= BUF_DRAIN;  // last word written.
                    end
                end
                BUF_DRAIN: begin
                    if (rd_fire && (out_cnt_q == LAST_CNT)) begin
                        phase_q <= BUF_FILL;  // last beat taken.
                    end
                end
                default: phase_q <= BUF_FILL;
            endcase
        end
    end

    // wraps to zero at the end of each phase.
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            addr_q <= '0;
        end else if (sram_ce) begin
            addr_q <= (addr_q == LAST_ADDR) ? '0 : addr_q + 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            rd_cnt_q  <= '0;
            out_cnt_q <= '0;
        end else if (phase_q == BUF_FILL) begin
            rd_cnt_q  <= '0;
            out_cnt_q <= '0;
        end else begin
            if (rd_issue) begin
                rd_cnt_q <= rd_cnt_q + 1'b1;
            end
            if (rd_fire) begin
                out_cnt_q <= out_cnt_q + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // read return and output register
    //////////////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            rd_pend_q <= '0;
        end else begin
            rd_pend_q[0] <= rd_issue || (rd_pend_q[0] && !ld_out);
            for (int s = 1; s < SRAM_READ_LAT; s++) begin
                rd_pend_q[s] <= rd_pend_q[s-1];
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            out_vld_q <= 1'b0;
        end else if (ld_out) begin
            out_vld_q <= 1'b1;
        end else if (rd_fire) begin
            out_vld_q <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (ld_out) begin
            out_data_q <= bank_rdata;
        end
    end

    //////////////////////////////////////////////////
    // banks
    //////////////////////////////////////////////////

    for (genvar b = 0; b < BANKS; b++) begin : g_bank
        sram_if #(
            .ADDR_W (ADDR_W),
            .DATA_W (DATA_W)
        ) bank_if ();

        assign bank_if.ce    = sram_ce;
        assign bank_if.mode  = sram_mode;
        assign bank_if.addr  = addr_q;
        assign bank_if.wdata = i_wr_data[b*DATA_W +: DATA_W];  // bank 0 in low bits.

        assign bank_rdata[b*DATA_W +: DATA_W] = bank_if.rdata;

        sram_sp #(
            .DEPTH  (DEPTH),
            .DATA_W (DATA_W)
        ) u_sram (
            .i_clk (i_clk),
            .bus   (bank_if.mem)
        );
    end

endmodule

`default_nettype wire

// ==== verif/acc_buffers_assertions.sv ====
`timescale 1ns/1ns
`default_nettype none

module acc_buffers_assertions #(
    parameter int unsigned DATA_BITS = 64
) (
    input logic                 i_clk,
    input logic                 i_rst_n,
    input logic                 i_wr_ready,
    input logic                 i_rd_valid,
    input logic                 i_rd_ready,
    input logic [DATA_BITS-1:0] i_rd_data
);

    //////////////////////////////////////////////////
    // handshake rules
    //////////////////////////////////////////////////

    // a buffer is either filling or draining.
    a_phase_exclusive: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        !(i_wr_ready && i_rd_valid)
    ) else $error("wr_ready and rd_valid high together");

    a_drain_hold: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (i_rd_valid && !i_rd_ready) |=> (i_rd_valid && $stable(i_rd_data))
    ) else $error("drain word changed under back-pressure");

    a_ready_after_reset: assert property (
        @(posedge i_clk)
        $rose(i_rst_n) |-> i_wr_ready
    ) else $error("wr_ready low after reset release");

endmodule

bind stream_buffer acc_buffers_assertions #(
    .DATA_BITS (BANKS * DATA_W)
) u_handshake_checks (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_wr_ready (o_wr_ready),
    .i_rd_valid (o_rd_valid),
    .i_rd_ready (i_rd_ready),
    .i_rd_data  (o_rd_data)
);

`default_nettype wire

// ==== verif/tb_acc_buffers.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_acc_buffers;

    import buf_cfg_pkg::*;

    localparam int ROUNDS      = 4;    // last round drains at full rate.
    localparam int STALL_LIMIT = 600;

    logic             clk = 1'b0;
    logic             rst_n;
    logic [2:0]       wr_valid;
    logic [2:0]       rd_ready;
    logic [2:0][63:0] wr_data;
    wire  [2:0]       wr_ready;
    wire  [2:0]       rd_valid;
    wire  [2:0][63:0] rd_data;
    integer           seed;

    always #50 clk = ~clk;

    // index 0 ibuf, 1 wbuf, 2 gbuf.
    acc_buffers i_acc_buffers (
        .i_clk           (clk),
        .i_rst_n         (rst_n),
        .i_ibuf_wr_valid (wr_valid[0]),
        .o_ibuf_wr_ready (wr_ready[0]),
        .i_ibuf_wr_data  (wr_data[0]),
        .o_ibuf_rd_valid (rd_valid[0]),
        .i_ibuf_rd_ready (rd_ready[0]),
        .o_ibuf_rd_data  (rd_data[0]),
        .i_wbuf_wr_valid (wr_valid[1]),
        .o_wbuf_wr_ready (wr_ready[1]),
        .i_wbuf_wr_data  (wr_data[1]),
        .o_wbuf_rd_valid (rd_valid[1]),
        .i_wbuf_rd_ready (rd_ready[1]),
        .o_wbuf_rd_data  (rd_data[1]),
        .i_gbuf_wr_valid (wr_valid[2]),
        .o_gbuf_wr_ready (wr_ready[2]),
        .i_gbuf_wr_data  (wr_data[2]),
        .o_gbuf_rd_valid (rd_valid[2]),
        .i_gbuf_rd_ready (rd_ready[2]),
        .o_gbuf_rd_data  (rd_data[2])
    );

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    function automatic string buf_name(input int b);
        case (b)
            0:       return "ibuf";
            1:       return "wbuf";
            default: return "gbuf";
        endcase
    endfunction

    function automatic int depth_of(input int b);
        case (b)
            0:       return IBUF_DEPTH;
            1:       return WBUF_DEPTH;
            default: return GBUF_DEPTH;
        endcase
    endfunction

    function automatic int percent();
        return int'($unsigned($random(seed)) % 100);
    endfunction

    function automatic logic [63:0] random_word();
        return {$random(seed), $random(seed)};
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Test FAILED");
        $fatal(1, "stopping at first error.");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            $display("Test FAILED");
            $fatal(1, "stopping at first mismatch.");
        end
    endtask

    //////////////////////////////////////////////////
    // producers and consumers
    //////////////////////////////////////////////////

    task automatic produce(input int b, input int duty);
        int sent;
        int idle;
        int total;
        bit took;
        sent  = 0;
        idle  = 0;
        took  = 1'b0;
        total = depth_of(b) * ROUNDS;
        wr_data[b] = random_word();
        while (sent < total) begin
            @(negedge clk);
            if (took) begin
                wr_data[b]  = random_word();  // new word only after a transfer.
                wr_valid[b] = 1'b0;
                took        = 1'b0;
            end
            if (!wr_valid[b]) begin
                wr_valid[b] = (percent() < duty);
            end
            @(posedge clk);
            if (wr_valid[b] && wr_ready[b]) begin
                sent++;
                idle = 0;
                took = 1'b1;
            end else begin
                idle++;
                if (idle > STALL_LIMIT) begin
                    report_failure($sformatf("%s write channel stalled", buf_name(b)));
                end
            end
        end
        @(negedge clk);
        wr_valid[b] = 1'b0;
    endtask

    task automatic consume(input int b, input int duty);
        int got;
        int idle;
        int total;
        got   = 0;
        idle  = 0;
        total = depth_of(b) * ROUNDS;
        while (got < total) begin
            @(negedge clk);
            rd_ready[b] = (got >= total - depth_of(b)) || (percent() < duty);
            @(posedge clk);
            if (rd_valid[b] && rd_ready[b]) begin
                got++;
                idle = 0;
            end else begin
                idle++;
                if (idle > STALL_LIMIT) begin
                    report_failure($sformatf("%s drain channel stalled", buf_name(b)));
                end
            end
        end
        @(negedge clk);
        rd_ready[b] = 1'b0;
    endtask

    //////////////////////////////////////////////////
    // model
    //////////////////////////////////////////////////

    for (genvar b = 0; b < 3; b++) begin : g_mon
        logic [63:0] exp_q [$];
        logic [63:0] exp_word;
        int          wr_cnt   = 0;
        int          rd_cnt   = 0;
        int          rounds   = 0;
        int          since_wr = 0;  // edges after the last write of a fill.
        bit          draining = 1'b0;

        always @(posedge clk) begin
            if (rst_n) begin
                check_value($sformatf("%s wr_ready", buf_name(b)),
                            64'(!draining), 64'(wr_ready[b]));
                if (!draining) begin
                    check_value($sformatf("%s rd_valid in fill", buf_name(b)),
                                64'd0, 64'(rd_valid[b]));
                end else if (rounds == ROUNDS - 1) begin
                    if (rd_cnt == 0) begin
                        check_value($sformatf("%s first rd_valid", buf_name(b)),
                                    64'(since_wr >= 2), 64'(rd_valid[b]));
                    end else begin
                        check_value($sformatf("%s full-rate drain", buf_name(b)),
                                    64'd1, 64'(rd_valid[b]));
                    end
                end
                since_wr++;
                if (wr_valid[b] && wr_ready[b]) begin
                    exp_q.push_back(wr_data[b]);
                    wr_cnt++;
                    if (wr_cnt == depth_of(b)) begin
                        wr_cnt   = 0;
                        draining = 1'b1;
                        since_wr = 0;
                    end
                end
                if (rd_valid[b] && rd_ready[b]) begin
                    if (exp_q.size() == 0) begin
                        report_failure($sformatf("%s drained a word never written",
                                                 buf_name(b)));
                    end else begin
                        exp_word = exp_q.pop_front();
                        check_value($sformatf("%s rd_data", buf_name(b)),
                                    exp_word, rd_data[b]);
                        rd_cnt++;
                        if (rd_cnt == depth_of(b)) begin
                            rd_cnt   = 0;
                            draining = 1'b0;
                            rounds++;
                        end
                    end
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        seed     = 32'hde45_f1f9;
        rst_n    = 1'b0;
        wr_valid = '0;
        rd_ready = '0;
        wr_data  = '0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        check_value("reset wr_ready", 64'd7, 64'(wr_ready));
        check_value("reset rd_valid", 64'd0, 64'(rd_valid));

        // different duty cycles per buffer.
        fork
            produce(0, 70);
            produce(1, 45);
            produce(2, 85);
            consume(0, 55);
            consume(1, 80);
            consume(2, 35);
        join

        // every buffer back in fill after its last drain.
        check_value("final wr_ready", 64'd7, 64'(wr_ready));
        check_value("final rd_valid", 64'd0, 64'(rd_valid));
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire
